// File: raster_cfg.f
hw/raster_cfg_pkg.sv
hw/command_parser.sv
hw/register_bank.sv
hw/span_filler.sv
hw/raster_cfg_top.sv
bench/raster_cfg_props.sv
bench/raster_cfg_tb.sv

// File: Makefile
# Verilator flow for the rasterizer command front end
# make lint   checks the RTL
# make sim    builds and runs the testbench, fails if the log reports a failure
# make clean  removes the build directory and the log

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module raster_cfg_top -f raster_cfg.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module raster_cfg_tb \
		-f raster_cfg.f -Mdir obj_dir -o raster_cfg_sim
	./obj_dir/raster_cfg_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/raster_cfg_tb.sv
//**************************************************************************
// Testbench for the rasterizer command front end.
// Sends register writes, sync and unknown commands into the DUT and drives
// the pixel sink, while the checker instance judges every output.
// Prints one line per test, the closing counts and the final verdict.
//**************************************************************************

`timescale 1ns/100ps

module raster_cfg_tb;
    import raster_cfg_pkg::*;

    // Six tests, each well inside its share of the cycle budget
    localparam int test_cycles = 2000;
    localparam int margin_cycles = 500;
    localparam int wait_limit = 300;

    logic                   aclk = 1'b0;
    logic                   resetn;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic [cmd_width-1:0]   cmd_data;
    logic                   pixel_valid;
    logic                   pixel_ready;
    logic [coord_width-1:0] pixel_x;
    logic [coord_width-1:0] pixel_y;
    logic [color_width-1:0] pixel_color;
    logic                   sync_valid;
    logic [tag_width-1:0]   sync_tag;

    // Random stalls on the pixel sink when set
    logic                   ready_random;
    // Shadow of the span bounds, used only to count the pixels to wait for
    logic [coord_width-1:0] shadow_xs;
    logic [coord_width-1:0] shadow_xe;
    int                     pixels_expected;
    int                     tb_errors;
    int                     errors_before;
    int                     test_number;
    int                     tests_passed;
    int                     tests_failed;

    always #50 aclk = ~aclk;

    raster_cfg_top DUT (
        .aclk        (aclk),
        .resetn      (resetn),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_color (pixel_color),
        .sync_valid  (sync_valid),
        .sync_tag    (sync_tag)
    );

    raster_cfg_props u_props (.*);

    // Sink side, roughly half the cycles stall in random mode
    always @(negedge aclk)
    begin
        pixel_ready = ready_random ? ($urandom % 2) == 0 : 1'b1;
    end

    function automatic int span_length(input logic [coord_width-1:0] xs,
                                       input logic [coord_width-1:0] xe);
        return (xe >= xs) ? int'(xe) - int'(xs) + 1 : 0;
    endfunction

    // Random upper bits around a chosen low field
    function automatic logic [reg_width-1:0] pad_random(input logic [reg_width-1:0] low);
        logic [reg_width-1:0] mask;
        mask = (32'd1 << coord_width) - 1;
        return ($urandom & ~mask) | (low & mask);
    endfunction

    function automatic logic [cmd_width-1:0] write_header(input int offset, input int count);
        cmd_header_t hdr;
        hdr.wr.opcode = op_reg_write;
        hdr.wr.offset = 4'(offset);
        hdr.wr.count = 8'(count);
        hdr.wr.reserved = '0;
        return hdr;
    endfunction

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_word(input logic [cmd_width-1:0] word);
        int waited;
        waited = 0;
        cmd_data = word;
        cmd_valid = 1'b1;
        // Ready only moves on a rising edge, so what is seen here holds
        while (!cmd_ready && waited < wait_limit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (!cmd_ready)
        begin
            tb_errors++;
            $display("%0t ns: command word %h was never accepted", $time, word);
        end
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic write_regs(input int offset, input int count,
                              input logic [reg_width-1:0] w0, w1, w2, w3);
        logic [reg_width-1:0] words [4];
        int slot;
        words[0] = w0;
        words[1] = w1;
        words[2] = w2;
        words[3] = w3;
        send_word(write_header(offset, count));
        for (int i = 0; i < count; i++)
        begin
            send_word(words[i]);
            slot = (offset + i) % bank_size;
            if (slot == int'(reg_span_x_start))
            begin
                shadow_xs = words[i][coord_width-1:0];
            end
            if (slot == int'(reg_span_x_end))
            begin
                shadow_xe = words[i][coord_width-1:0];
            end
        end
        if (count > 0)
        begin
            pixels_expected += span_length(shadow_xs, shadow_xe);
        end
    endtask

    task automatic random_span(input bit empty);
        logic [reg_width-1:0] xs;
        logic [reg_width-1:0] xe;
        xs = 16 + $urandom % 200;
        xe = empty ? xs - 1 - $urandom % 8 : xs + $urandom % 16;
        write_regs(0, 4, $urandom, pad_random(xs), pad_random(xe), $urandom);
    endtask

    task automatic send_sync(input logic [tag_width-1:0] tag);
        cmd_header_t hdr;
        hdr.sync.opcode = op_sync;
        hdr.sync.tag = tag;
        send_word(hdr);
    endtask

    task automatic wait_pixels();
        int waited;
        waited = 0;
        while (u_props.pixel_count != pixels_expected && waited < wait_limit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (u_props.pixel_count != pixels_expected)
        begin
            tb_errors++;
            $display("%0t ns: pixel stream stopped at %0d of %0d pixels",
                $time, u_props.pixel_count, pixels_expected);
        end
    endtask

    // The front end is idle once it takes headers again
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!cmd_ready && waited < wait_limit)
        begin
            @(negedge aclk);
            waited++;
        end
        if (!cmd_ready)
        begin
            tb_errors++;
            $display("%0t ns: front end never returned to idle", $time);
        end
        // One more edge so that a pending sync pulse is judged in this test
        @(negedge aclk);
    endtask

    task automatic finish_test(input string name);
        int errors;
        wait_idle();
        errors = u_props.error_count + tb_errors - errors_before;
        errors_before = u_props.error_count + tb_errors;
        test_number++;
        if (errors == 0)
        begin
            tests_passed++;
            $display("test %0d %s: ok", test_number, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: FAILED with %0d errors", test_number, name, errors);
        end
    endtask

    initial
    begin
        void'($urandom(14));
        resetn = 1'b0;
        cmd_valid = 1'b0;
        cmd_data = '0;
        pixel_ready = 1'b0;
        ready_random = 1'b0;
        shadow_xs = '0;
        shadow_xe = '0;
        pixels_expected = 0;
        tb_errors = 0;
        errors_before = 0;
        test_number = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        resetn = 1'b1;
        finish_test("reset state");

        // Full writes, then two spans that end left of their start
        for (int i = 0; i < 3; i++)
        begin
            random_span(1'b0);
        end
        random_span(1'b1);
        random_span(1'b1);
        wait_pixels();
        finish_test("full register writes");

        // New colour only, then a write that wraps from x end round to y
        random_span(1'b0);
        write_regs(3, 1, $urandom, '0, '0, '0);
        write_regs(2, 3, pad_random(shadow_xs + 5), $urandom, $urandom, '0);
        wait_pixels();
        finish_test("partial writes with offset");

        ready_random = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            random_span(1'b0);
        end
        wait_pixels();
        finish_test("random back-pressure");

        // The first sync lands in the middle of a stalled span
        write_regs(0, 4, $urandom, pad_random(40), pad_random(55), $urandom);
        send_sync(tag_width'($urandom));
        wait_pixels();
        send_sync(tag_width'($urandom));
        ready_random = 1'b0;
        finish_test("sync held off by a span");

        send_word({4'h7, 28'($urandom)});
        write_regs(1, 0, '0, '0, '0, '0);
        send_word({4'hF, 28'($urandom)});
        send_word({4'h0, 28'($urandom)});
        random_span(1'b0);
        send_sync(tag_width'($urandom));
        wait_pixels();
        finish_test("unknown and empty commands");

        $display("%0d tests run, %0d ok, %0d failing", test_number, tests_passed, tests_failed);
        if (tests_failed == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog over the whole run
    initial
    begin
        repeat (test_cycles + margin_cycles) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", test_cycles + margin_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: bench/raster_cfg_props.sv
//**************************************************************************
// Checker for the rasterizer command front end.
// Rebuilds the span registers from the accepted command words and judges
// every pixel and sync pulse on the DUT ports with concurrent assertions.
// The testbench reads error_count and pixel_count from the instance.
//**************************************************************************

`timescale 1ns/100ps

module raster_cfg_props
    import raster_cfg_pkg::*;
(
    input logic                   aclk,
    input logic                   resetn,
    input logic                   cmd_valid,
    input logic                   cmd_ready,
    input logic [cmd_width-1:0]   cmd_data,
    input logic                   pixel_valid,
    input logic                   pixel_ready,
    input logic [coord_width-1:0] pixel_x,
    input logic [coord_width-1:0] pixel_y,
    input logic [color_width-1:0] pixel_color,
    input logic                   sync_valid,
    input logic [tag_width-1:0]   sync_tag
);

    int error_count = 0;
    int pixel_count = 0;

    // Model of the four span registers and of the header/payload phase
    logic [reg_width-1:0]   regs_q [bank_size];
    logic [reg_width-1:0]   regs_d [bank_size];
    logic                   in_payload;
    logic [7:0]             words_left;
    logic [3:0]             offset_q;
    int                     word_index;
    int                     slot;

    // Next pixel that the span being drawn must deliver
    logic                   exp_busy;
    logic [coord_width-1:0] exp_x;
    logic [coord_width-1:0] exp_x_end;
    logic [coord_width-1:0] exp_y;
    logic [color_width-1:0] exp_color;
    // Cycles in which a pixel is owed but pixel_valid is low
    int                     stall_cycles;

    // A sync pulse is owed in the cycle after its header was taken
    logic                   sync_expect;
    logic [tag_width-1:0]   sync_exp_tag;

    cmd_header_t            hdr;
    logic                   cmd_fire;
    logic                   pixel_fire;

    assign hdr = cmd_data;
    assign cmd_fire = cmd_valid && cmd_ready;
    assign pixel_fire = pixel_valid && pixel_ready;

    always @(posedge aclk)
    begin
        if (!resetn)
        begin
            in_payload <= 1'b0;
            exp_busy <= 1'b0;
            sync_expect <= 1'b0;
            stall_cycles <= 0;
        end
        else
        begin
            regs_d = regs_q;
            sync_expect <= 1'b0;
            stall_cycles <= (exp_busy && !pixel_valid) ? stall_cycles + 1 : 0;
            // Each accepted pixel moves the expectation one step right
            if (pixel_fire)
            begin
                pixel_count <= pixel_count + 1;
                if (exp_busy && exp_x == exp_x_end)
                begin
                    exp_busy <= 1'b0;
                end
                else
                begin
                    exp_x <= exp_x + 1'b1;
                end
            end
            if (cmd_fire && !in_payload)
            begin
                if (hdr.wr.opcode == op_reg_write && hdr.wr.count != 8'd0)
                begin
                    in_payload <= 1'b1;
                    words_left <= hdr.wr.count;
                    offset_q <= hdr.wr.offset;
                    word_index <= 0;
                end
                else if (hdr.sync.opcode == op_sync)
                begin
                    sync_expect <= 1'b1;
                    sync_exp_tag <= hdr.sync.tag;
                end
            end
            else if (cmd_fire)
            begin
                // Target register wraps around the end of the bank
                slot = (word_index + int'(offset_q)) % bank_size;
                regs_d[slot] = cmd_data;
                regs_q <= regs_d;
                word_index <= word_index + 1;
                words_left <= words_left - 8'd1;
                if (words_left == 8'd1)
                begin
                    in_payload <= 1'b0;
                    // A span whose end lies left of its start owes no pixel
                    if (regs_d[reg_span_x_end][coord_width-1:0]
                        >= regs_d[reg_span_x_start][coord_width-1:0])
                    begin
                        exp_busy <= 1'b1;
                        exp_x <= regs_d[reg_span_x_start][coord_width-1:0];
                        exp_x_end <= regs_d[reg_span_x_end][coord_width-1:0];
                        exp_y <= regs_d[reg_span_y][coord_width-1:0];
                        exp_color <= regs_d[reg_span_color][color_width-1:0];
                    end
                end
            end
        end
    end

    // Leaving reset the stream takes headers and nothing is output
    assert property (@(posedge aclk) !resetn |=> (cmd_ready && !pixel_valid && !sync_valid))
    else
    begin
        error_count++;
        $display("[ERROR] %0t ns: cmd_ready/pixel_valid/sync_valid expected 1/0/0, got %b/%b/%b",
            $time, $sampled(cmd_ready), $sampled(pixel_valid), $sampled(sync_valid));
    end

    assert property (@(posedge aclk) disable iff (!resetn) pixel_fire |-> exp_busy)
    else
    begin
        error_count++;
        $display("%0t ns: a pixel at x %0d was accepted while no pixel was owed",
            $time, $sampled(pixel_x));
    end

    assert property (@(posedge aclk) disable iff (!resetn)
        (pixel_fire && exp_busy) |-> pixel_x == exp_x)
    else
    begin
        error_count++;
        $display("[ERROR] %0t ns: pixel_x expected %0d, got %0d",
            $time, $sampled(exp_x), $sampled(pixel_x));
    end

    assert property (@(posedge aclk) disable iff (!resetn)
        (pixel_fire && exp_busy) |-> pixel_y == exp_y)
    else
    begin
        error_count++;
        $display("[ERROR] %0t ns: pixel_y expected %0d, got %0d",
            $time, $sampled(exp_y), $sampled(pixel_y));
    end

    assert property (@(posedge aclk) disable iff (!resetn)
        (pixel_fire && exp_busy) |-> pixel_color == exp_color)
    else
    begin
        error_count++;
        $display("[ERROR] %0t ns: pixel_color expected %h, got %h",
            $time, $sampled(exp_color), $sampled(pixel_color));
    end

    // A stalled pixel keeps its values until the sink takes it
    assert property (@(posedge aclk) disable iff (!resetn)
        (pixel_valid && !pixel_ready) |=> (pixel_valid && $stable(pixel_x)
            && $stable(pixel_y) && $stable(pixel_color)))
    else
    begin
        error_count++;
        $display("%0t ns: pixel outputs changed or dropped while stalled", $time);
    end

    // Pixels start one cycle after the request and then flow without gaps
    assert property (@(posedge aclk) disable iff (!resetn) stall_cycles < 2)
    else
    begin
        error_count++;
        $display("%0t ns: pixel_valid stayed low while span pixels were owed", $time);
    end

    assert property (@(posedge aclk) disable iff (!resetn)
        (cmd_fire && !in_payload) |-> !exp_busy)
    else
    begin
        error_count++;
        $display("%0t ns: a header was accepted while a span was still drawing", $time);
    end

    assert property (@(posedge aclk) disable iff (!resetn) sync_valid |-> sync_expect)
    else
    begin
        error_count++;
        $display("%0t ns: sync pulse without an accepted sync command", $time);
    end

    assert property (@(posedge aclk) disable iff (!resetn) sync_expect |-> sync_valid)
    else
    begin
        error_count++;
        $display("%0t ns: an accepted sync command gave no sync pulse", $time);
    end

    assert property (@(posedge aclk) disable iff (!resetn)
        (sync_valid && sync_expect) |-> sync_tag == sync_exp_tag)
    else
    begin
        error_count++;
        $display("[ERROR] %0t ns: sync_tag expected %h, got %h",
            $time, $sampled(sync_exp_tag), $sampled(sync_tag));
    end

    assert property (@(posedge aclk) disable iff (!resetn) sync_valid |-> !exp_busy)
    else
    begin
        error_count++;
        $display("%0t ns: sync pulse came before the last pixel of the span", $time);
    end

endmodule

// File: hw/raster_cfg_top.sv
//**************************************************************************
// Top level of the rasterizer command front end.
// Connects the command parser, the span register bank and the span
// filler. Takes a 32-bit command stream, returns pixels and sync tags.
//**************************************************************************

`timescale 1ns/100ps

module raster_cfg_top
    import raster_cfg_pkg::*;
(
    input  logic                   aclk,
    input  logic                   resetn,

    // Command stream
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [cmd_width-1:0]   cmd_data,

    // Pixel stream
    output logic                   pixel_valid,
    input  logic                   pixel_ready,
    output logic [coord_width-1:0] pixel_x,
    output logic [coord_width-1:0] pixel_y,
    output logic [color_width-1:0] pixel_color,

    // Sync echo, a single-cycle pulse
    output logic                   sync_valid,
    output logic [tag_width-1:0]   sync_tag
);

    // Parser to bank beats
    logic                   wr_valid;
    logic                   wr_last;
    logic [cmd_width-1:0]   wr_data;
    logic [index_width-1:0] wr_offset;

    // Bank to filler handshake
    logic                   update_req;
    logic                   update_ack;

    // Span registers
    logic [coord_width-1:0] span_y;
    logic [coord_width-1:0] span_x_start;
    logic [coord_width-1:0] span_x_end;
    logic [color_width-1:0] span_color;

    command_parser u_parser (
        .aclk       (aclk),
        .resetn     (resetn),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_data   (cmd_data),
        .update_req (update_req),
        .update_ack (update_ack),
        .wr_valid   (wr_valid),
        .wr_last    (wr_last),
        .wr_data    (wr_data),
        .wr_offset  (wr_offset),
        .sync_valid (sync_valid),
        .sync_tag   (sync_tag)
    );

    register_bank u_bank (
        .aclk         (aclk),
        .resetn       (resetn),
        .wr_valid     (wr_valid),
        .wr_last      (wr_last),
        .wr_data      (wr_data),
        .wr_offset    (wr_offset),
        .update_req   (update_req),
        .update_ack   (update_ack),
        .span_y       (span_y),
        .span_x_start (span_x_start),
        .span_x_end   (span_x_end),
        .span_color   (span_color)
    );

    span_filler u_filler (
        .aclk         (aclk),
        .resetn       (resetn),
        .update_req   (update_req),
        .update_ack   (update_ack),
        .span_y       (span_y),
        .span_x_start (span_x_start),
        .span_x_end   (span_x_end),
        .span_color   (span_color),
        .pixel_valid  (pixel_valid),
        .pixel_ready  (pixel_ready),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .pixel_color  (pixel_color)
    );

endmodule

// File: hw/span_filler.sv
//**************************************************************************
// Scanline span filler.
// On an update request it latches the span registers and emits one pixel
// per accepted cycle from x start to x end on a valid/ready stream.
// Completion is reported on the ack side of the four-phase handshake.
//**************************************************************************

`timescale 1ns/100ps

module span_filler
    import raster_cfg_pkg::*;
(
    input  logic                   aclk,
    input  logic                   resetn,

    // Acknowledge side of the update handshake
    input  logic                   update_req,
    output logic                   update_ack,

    // Span registers from the bank
    input  logic [coord_width-1:0] span_y,
    input  logic [coord_width-1:0] span_x_start,
    input  logic [coord_width-1:0] span_x_end,
    input  logic [color_width-1:0] span_color,

    // Pixel stream out
    output logic                   pixel_valid,
    input  logic                   pixel_ready,
    output logic [coord_width-1:0] pixel_x,
    output logic [coord_width-1:0] pixel_y,
    output logic [color_width-1:0] pixel_color
);

    // The FSM is held in two flags
    // Idle has both low, draw has drawing high, done has update_ack high
    logic                   drawing;

    // Current x and the latched span
    logic [coord_width-1:0] x_count;
    logic [coord_width-1:0] x_end_q;
    logic [coord_width-1:0] y_q;
    logic [color_width-1:0] color_q;

    logic span_empty;
    logic start;
    logic pixel_fire;
    logic last_pixel;

    // A span whose end lies left of its start has no pixel at all
    assign span_empty = span_x_end < span_x_start;

    // A fresh request is seen only from idle
    assign start = update_req && !update_ack && !drawing;

    assign pixel_fire = pixel_valid && pixel_ready;
    assign last_pixel = pixel_fire && (x_count == x_end_q);

    // Control flags
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            drawing <= 1'b0;
            update_ack <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                if (span_empty)
                begin
                    // Nothing to draw, go straight to done
                    update_ack <= 1'b1;
                end
                else
                begin
                    drawing <= 1'b1;
                end
            end
            if (last_pixel)
            begin
                drawing <= 1'b0;
                update_ack <= 1'b1;
            end
            // Ack is held in done until the bank lets go of its request
            if (update_ack && !update_req)
            begin
                update_ack <= 1'b0;
            end
        end
    end

    // Span latch and x counter
    always_ff @(posedge aclk)
    begin
        if (start)
        begin
            x_count <= span_x_start;
            x_end_q <= span_x_end;
            y_q <= span_y;
            color_q <= span_color;
        end
        else if (pixel_fire)
        begin
            x_count <= x_count + 1'b1;
        end
    end

    assign pixel_valid = drawing;
    assign pixel_x = x_count;
    assign pixel_y = y_q;
    assign pixel_color = color_q;

    // A stalled pixel keeps its values until the sink takes it
    assert property (@(posedge aclk) disable iff (!resetn)
        (pixel_valid && !pixel_ready) |=> (pixel_valid && $stable(pixel_x)
            && $stable(pixel_y) && $stable(pixel_color)));

    // Ack only ever answers a live request from the bank
    assert property (@(posedge aclk) disable iff (!resetn)
        $rose(update_ack) |-> update_req);

endmodule

// File: hw/register_bank.sv
//**************************************************************************
// Span register bank.
// Deserializes payload beats into four registers, starting at the offset
// from the header. After the last beat it requests an update from the
// span filler with a four-phase req/ack handshake.
//**************************************************************************

`timescale 1ns/100ps

module register_bank
    import raster_cfg_pkg::*;
(
    input  logic                   aclk,
    input  logic                   resetn,

    // Payload beats from the parser
    input  logic                   wr_valid,
    input  logic                   wr_last,
    input  logic [cmd_width-1:0]   wr_data,
    input  logic [index_width-1:0] wr_offset,

    // Request side of the update handshake
    output logic                   update_req,
    input  logic                   update_ack,

    // Register contents towards the filler
    output logic [coord_width-1:0] span_y,
    output logic [coord_width-1:0] span_x_start,
    output logic [coord_width-1:0] span_x_end,
    output logic [color_width-1:0] span_color
);

    logic [reg_width-1:0]   reg_mem [bank_size];
    // Position within the current register write
    logic [index_width-1:0] reg_index;
    // Target register, wraps around inside the bank
    logic [index_width-1:0] wr_addr;

    assign wr_addr = reg_index + wr_offset;

    // Register storage
    always_ff @(posedge aclk)
    begin
        if (wr_valid)
        begin
            reg_mem[wr_addr] <= wr_data[reg_width-1:0];
        end
    end

    // Running index and update request
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            reg_index <= '0;
            update_req <= 1'b0;
        end
        else
        begin
            // Request is withdrawn once the filler reports the span done
            if (update_ack)
            begin
                update_req <= 1'b0;
            end
            if (wr_valid)
            begin
                if (wr_last)
                begin
                    reg_index <= '0;
                    update_req <= 1'b1;
                end
                else
                begin
                    reg_index <= reg_index + 1'b1;
                end
            end
        end
    end

    // Only the low bits of each register are meaningful to the filler
    assign span_y = reg_mem[reg_span_y][coord_width-1:0];
    assign span_x_start = reg_mem[reg_span_x_start][coord_width-1:0];
    assign span_x_end = reg_mem[reg_span_x_end][coord_width-1:0];
    assign span_color = reg_mem[reg_span_color][color_width-1:0];

    // A new request must wait until the filler has dropped its ack
    assert property (@(posedge aclk) disable iff (!resetn)
        (!update_req && update_ack) |=> !update_req);

endmodule

// File: hw/command_parser.sv
//**************************************************************************
// Command stream decoder.
// Splits the 32-bit stream into headers and payload words. Register
// writes go out as beats with an offset and a last flag, sync commands
// produce a one-cycle tag pulse once no span is pending.
//**************************************************************************

`timescale 1ns/100ps

module command_parser
    import raster_cfg_pkg::*;
(
    input  logic                   aclk,
    input  logic                   resetn,

    // Command stream in
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [cmd_width-1:0]   cmd_data,

    // Handshake state of the bank and the filler
    input  logic                   update_req,
    input  logic                   update_ack,

    // Payload beats towards the register bank
    output logic                   wr_valid,
    output logic                   wr_last,
    output logic [cmd_width-1:0]   wr_data,
    output logic [index_width-1:0] wr_offset,

    // Sync echo
    output logic                   sync_valid,
    output logic [tag_width-1:0]   sync_tag
);

    // High while payload words of a register write are expected
    logic                   in_payload;
    // Payload words still to come in the current register write
    logic [7:0]             words_left;
    logic [index_width-1:0] offset_q;

    // The incoming word as a header, only meaningful outside the payload
    cmd_header_t header;

    logic hdr_accept;
    logic beat;

    assign header = cmd_data;

    // Headers wait while a span is requested or still being acknowledged
    // Payload words are always taken, the bank never stalls
    assign cmd_ready = in_payload || !(update_req || update_ack);

    assign hdr_accept = !in_payload && cmd_valid && cmd_ready;
    assign beat = in_payload && cmd_valid;

    // Beats leave in the same cycle the word is accepted
    assign wr_valid = beat;
    assign wr_last = in_payload && (words_left == 8'd1);
    assign wr_data = cmd_data;
    assign wr_offset = offset_q;

    // Header and payload phase, plus the sync pulse
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            in_payload <= 1'b0;
            sync_valid <= 1'b0;
        end
        else
        begin
            sync_valid <= 1'b0;
            if (hdr_accept)
            begin
                case (header.wr.opcode)
                    op_reg_write:
                    begin
                        // A write with no words stays in the header phase
                        if (header.wr.count != 8'd0)
                        begin
                            in_payload <= 1'b1;
                        end
                    end
                    op_sync:
                    begin
                        sync_valid <= 1'b1;
                    end
                    default:
                    begin
                        // Unknown opcodes are one word long and dropped
                    end
                endcase
            end
            if (beat && wr_last)
            begin
                in_payload <= 1'b0;
            end
        end
    end

    // Word counter, offset and tag are payload and carry no reset
    always_ff @(posedge aclk)
    begin
        if (hdr_accept)
        begin
            words_left <= header.wr.count;
            offset_q <= header.wr.offset[index_width-1:0];
            if (header.sync.opcode == op_sync)
            begin
                sync_tag <= header.sync.tag;
            end
        end
        else if (beat)
        begin
            words_left <= words_left - 8'd1;
        end
    end

    // The bank only raises its request after the last beat, so no beat
    // may ever overlap a pending request
    assert property (@(posedge aclk) disable iff (!resetn)
        wr_valid |-> !update_req);

endmodule

// File: hw/raster_cfg_pkg.sv
//**************************************************************************
// Shared definitions for the rasterizer command front end.
// Holds the command opcodes, the span register map, the bus widths and
// the two views of a command header word.
// Modules pull these in with a wildcard import in their module header.
//**************************************************************************

package raster_cfg_pkg;

    // Width of one word on the command stream
    localparam int cmd_width = 32;

    // Register bank geometry, one register is written per payload beat
    localparam int reg_width = 32;
    localparam int bank_size = 4;
    localparam int index_width = 2;

    // Pixel stream field widths
    localparam int coord_width = 12;
    localparam int color_width = 24;

    // A sync tag fills everything below the opcode
    localparam int tag_width = 28;

    // Opcodes in the top nibble of a header, anything else is skipped
    localparam logic [3:0] op_reg_write = 4'h1;
    localparam logic [3:0] op_sync = 4'h2;

    // Register map of the span filler
    localparam logic [index_width-1:0] reg_span_y = 2'd0;
    localparam logic [index_width-1:0] reg_span_x_start = 2'd1;
    localparam logic [index_width-1:0] reg_span_x_end = 2'd2;
    localparam logic [index_width-1:0] reg_span_color = 2'd3;

    // A header word seen either as a register write or as a sync command
    // The opcode sits in the top four bits in both views
    typedef union packed {
        struct packed {
            logic [3:0]  opcode;
            logic [3:0]  offset;
            logic [7:0]  count;
            logic [15:0] reserved;
        } wr;
        struct packed {
            logic [3:0]           opcode;
            logic [tag_width-1:0] tag;
        } sync;
    } cmd_header_t;

endpackage
